// ==== Makefile ====
TOP := tb_uart_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+. uart_pkg.sv uart_tx.sv uart_rx.sv uart_top.sv \
		--top-module uart_top
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sources.f ====
+incdir+.
uart_pkg.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_checker.sv
tb_uart_top.sv

// ==== tb_uart_top.sv ====
// UART subsystem testbench
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_uart_top;

    localparam int BIT_CYCLES   = `UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int N_TESTS      = 12;
    localparam int WATCHDOG_NS  = N_TESTS * 400 * BIT_CYCLES * 40;

    typedef enum logic [1:0] {MODE_LOOP, MODE_BAD_STOP, MODE_GLITCH} mode_e;
    typedef enum logic [1:0] {EXP_BYTE, EXP_FRAME_ERR, EXP_NONE} expect_e;

    logic       clk;
    logic       arstn;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_ready;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       frame_err;
    logic       uart_tx;
    logic       drv_line;
    logic       loopback;   // 1 routes uart_tx_o back into uart_rx_i

    mode_e      mode_tab [N_TESTS];
    logic [7:0] byte_tab [N_TESTS];
    expect_e    exp_tab  [N_TESTS];
    logic [7:0] tx_sent_q [$];   // Accepted bytes, oldest first
    logic [7:0] rx_byte_q [$];
    int         seed;
    int         err_count  = 0;
    int         rx_cnt     = 0;
    int         ferr_cnt   = 0;
    int         accept_cnt = 0;
    int         ok_tests   = 0;
    int         bad_tests  = 0;

    uart_top DUT (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .tx_valid_i  (tx_valid),
        .tx_data_i   (tx_data),
        .tx_ready_o  (tx_ready),
        .rx_valid_o  (rx_valid),
        .rx_data_o   (rx_data),
        .frame_err_o (frame_err),
        .uart_tx_o   (uart_tx),
        .uart_rx_i   (loopback ? uart_tx : drv_line)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run is hung", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0d ns %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%0d ns %s", $time, msg);
        err_count++;
    endtask

    task automatic finish_test(input string label, input int base_err);
        if (err_count == base_err) begin
            ok_tests++;
            $display("%0d ns  %s  ok", $time, label);
        end else begin
            bad_tests++;
            $display("%0d ns  %s  %0d errors", $time, label, err_count - base_err);
        end
    endtask

    task automatic set_entry(input int idx, input mode_e mode, input logic [7:0] b,
                             input expect_e exp);
        mode_tab[idx] = mode;
        byte_tab[idx] = b;
        exp_tab[idx]  = exp;
    endtask

    task automatic build_table();
        set_entry(0, MODE_LOOP, 8'h00, EXP_BYTE);
        set_entry(1, MODE_LOOP, 8'hFF, EXP_BYTE);
        set_entry(2, MODE_LOOP, 8'h55, EXP_BYTE);
        set_entry(3, MODE_LOOP, 8'hA5, EXP_BYTE);
        set_entry(4, MODE_LOOP, 8'($random(seed)), EXP_BYTE);
        set_entry(5, MODE_LOOP, 8'($random(seed)), EXP_BYTE);
        set_entry(6, MODE_LOOP, 8'($random(seed)), EXP_BYTE);
        set_entry(7, MODE_BAD_STOP, 8'h3C, EXP_FRAME_ERR);
        set_entry(8, MODE_LOOP, 8'h81, EXP_BYTE);
        set_entry(9, MODE_GLITCH, 8'h00, EXP_NONE);
        set_entry(10, MODE_LOOP, 8'($random(seed)), EXP_BYTE);
        set_entry(11, MODE_LOOP, 8'h7E, EXP_BYTE);
    endtask

    // Called on a falling edge, returns on the falling edge after the accept edge
    task automatic send_byte(input logic [7:0] b);
        tx_valid = 1'b1;
        tx_data  = b;
        while (!tx_ready) @(negedge clk);
        tx_sent_q.push_back(b);
        accept_cnt++;
        @(negedge clk);
    endtask

    task automatic drive_frame(input logic [7:0] b, input logic stop_bit);
        int k;
        drv_line = 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (k = 0; k < 8; k++) begin
            drv_line = b[k];   // LSB first
            repeat (BIT_CYCLES) @(negedge clk);
        end
        drv_line = stop_bit;
        repeat (BIT_CYCLES) @(negedge clk);
        drv_line = 1'b1;
    endtask

    task automatic check_result(input int i, input int rx_base, input int ferr_base);
        int   n;
        logic seen;
        n = 0;
        while (rx_cnt == rx_base && ferr_cnt == ferr_base && n < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            n++;
        end
        seen = (rx_cnt != rx_base) || (ferr_cnt != ferr_base);
        if (exp_tab[i] == EXP_FRAME_ERR) begin
            repeat (2 * BIT_CYCLES) @(negedge clk);   // Let the receiver settle on idle
        end
        if (exp_tab[i] != EXP_NONE && !seen) begin
            report_problem($sformatf("Timeout: no receive strobe in test %0d", i));
        end else begin
            check_value("rx_valid_o count", 32'(rx_cnt - rx_base),
                        (exp_tab[i] == EXP_BYTE) ? 1 : 0);
            check_value("frame_err_o count", 32'(ferr_cnt - ferr_base),
                        (exp_tab[i] == EXP_FRAME_ERR) ? 1 : 0);
            if (exp_tab[i] == EXP_BYTE && rx_byte_q.size() > 0) begin
                check_value("rx_data_o", 32'(rx_byte_q.pop_front()), 32'(byte_tab[i]));
            end
        end
    endtask

    // Strobes are registers, so the value before the edge is the settled one
    always @(posedge clk) begin
        if (arstn && rx_valid) begin
            rx_byte_q.push_back(rx_data);
            rx_cnt++;
        end
        if (arstn && frame_err) begin
            ferr_cnt++;
        end
    end

    initial begin : line_monitor
        logic       prev;
        logic [7:0] bits;
        int         k;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (arstn && prev && !uart_tx) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);   // Middle of the start bit
                check_value("uart_tx_o start bit", 32'(uart_tx), 0);
                for (k = 0; k < 8; k++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    bits[k] = uart_tx;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                check_value("uart_tx_o stop bit", 32'(uart_tx), 1);
                if (tx_sent_q.size() == 0) begin
                    report_problem("Frame seen on uart_tx_o without an accepted handshake");
                end else begin
                    check_value("uart_tx_o data bits", 32'(bits), 32'(tx_sent_q.pop_front()));
                end
            end
            prev = uart_tx;
        end
    end

    initial begin : main_seq
        int i;
        int base_err;
        int rx_base;
        int ferr_base;
        arstn    = 1'b0;
        tx_valid = 1'b0;
        tx_data  = '0;
        drv_line = 1'b1;
        loopback = 1'b1;
        seed     = 17933;
        build_table();
        repeat (8) @(negedge clk);
        arstn = 1'b1;
        @(negedge clk);
        check_value("uart_tx_o", 32'(uart_tx), 1);
        check_value("tx_ready_o", 32'(tx_ready), 1);
        check_value("rx_valid_o", 32'(rx_valid), 0);
        check_value("frame_err_o", 32'(frame_err), 0);
        finish_test("reset state", 0);
        for (i = 0; i < N_TESTS; i++) begin
            base_err  = err_count;
            rx_base   = rx_cnt;
            ferr_base = ferr_cnt;
            loopback  = (mode_tab[i] == MODE_LOOP);
            if (mode_tab[i] == MODE_LOOP) begin
                send_byte(byte_tab[i]);
                // Valid stays high through a run of stream bytes
                if (i + 1 < N_TESTS && mode_tab[i + 1] == MODE_LOOP) begin
                    tx_data = byte_tab[i + 1];
                end else begin
                    tx_valid = 1'b0;
                end
            end else if (mode_tab[i] == MODE_BAD_STOP) begin
                drive_frame(byte_tab[i], 1'b0);
            end else begin
                drv_line = 1'b0;   // Shorter than half a bit
                repeat (4) @(negedge clk);
                drv_line = 1'b1;
            end
            check_result(i, rx_base, ferr_base);
            finish_test($sformatf("test %0d %s 0x%02h", i, mode_tab[i].name(), byte_tab[i]),
                        base_err);
        end
        check_value("rx_valid_o total vs handshakes", 32'(rx_cnt), 32'(accept_cnt));
        if (tx_sent_q.size() != 0) begin
            report_problem("Accepted bytes never appeared on uart_tx_o");
        end
        if (DUT.u_uart_checker.fail_cnt != 0) begin
            report_problem($sformatf("%0d assertion failures in uart_checker",
                                     DUT.u_uart_checker.fail_cnt));
        end
        $display("Tests: %0d ok, %0d with errors, %0d errors in total",
                 ok_tests, bad_tests, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== uart_cfg.svh ====
// UART frame configuration
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// System clock in Hz, 40 ns period
`define UART_CLK_FREQ 25_000_000

// Line rate in bit/s
`define UART_BAUD_RATE 1_562_500

// Clock cycles per bit, 16 at the rates above
`define UART_CLKS_PER_BIT (`UART_CLK_FREQ / `UART_BAUD_RATE)

// Data bits per 8N1 frame
`define UART_DATA_WIDTH 8

`endif

// ==== uart_checker.sv ====
// UART top-level assertions
`timescale 1ns/1ps

module uart_checker (
    input logic clk_i,
    input logic arstn_i,
    input logic tx_valid_i,
    input logic tx_ready_i,
    input logic tx_line_i,
    input logic rx_valid_i,
    input logic frame_err_i
);

    int fail_cnt = 0;   // Failed assertions so far

    // Good byte and framing error exclude each other
    a_strobe_excl: assert property (@(posedge clk_i) disable iff (!arstn_i)
        !(rx_valid_i && frame_err_i))
        else begin
            $error("rx_valid_o and frame_err_o high in the same cycle");
            fail_cnt++;
        end

    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!arstn_i)
        rx_valid_i |=> !rx_valid_i)
        else begin
            $error("rx_valid_o high for more than one cycle");
            fail_cnt++;
        end

    a_err_pulse: assert property (@(posedge clk_i) disable iff (!arstn_i)
        frame_err_i |=> !frame_err_i)
        else begin
            $error("frame_err_o high for more than one cycle");
            fail_cnt++;
        end

    a_ready_fall: assert property (@(posedge clk_i) disable iff (!arstn_i)
        $fell(tx_ready_i) |-> $past(tx_valid_i && tx_ready_i))   // Handshake edge only
        else begin
            $error("tx_ready_o fell without an accepted handshake");
            fail_cnt++;
        end

    a_idle_line: assert property (@(posedge clk_i) disable iff (!arstn_i)
        tx_ready_i |-> tx_line_i)
        else begin
            $error("uart_tx_o low while tx_ready_o is high");
            fail_cnt++;
        end

endmodule

bind uart_top uart_checker u_uart_checker (
    .clk_i       (clk_i),
    .arstn_i     (arstn_i),
    .tx_valid_i  (tx_valid_i),
    .tx_ready_i  (tx_ready_o),
    .tx_line_i   (uart_tx_o),
    .rx_valid_i  (rx_valid_o),
    .frame_err_i (frame_err_o)
);

// ==== uart_pkg.sv ====
// UART state types
package uart_pkg;

    // Transmitter frame sequence
    typedef enum logic [2:0] {
        TX_IDLE  = 3'd0,
        TX_START = 3'd1,
        TX_DATA  = 3'd2,
        TX_STOP  = 3'd3,
        TX_GAP   = 3'd4   // One idle cycle before the next handshake
    } tx_state_e;

    // Receiver frame sequence
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,  // Waiting for mid start bit
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

endpackage

// ==== uart_rx.sv ====
// UART receiver
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        arstn_i,
    input  logic                        uart_rx_i,
    output logic                        rx_valid_o,
    output logic [`UART_DATA_WIDTH-1:0] rx_data_o,
    output logic                        frame_err_o
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`UART_DATA_WIDTH);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(`UART_DATA_WIDTH - 1);

    logic [1:0]                  sync_q;
    logic                        rx_line;
    rx_state_e                   state_q;
    logic [CNT_W-1:0]            cnt_q;
    logic [IDX_W-1:0]            bit_idx_q;
    logic [`UART_DATA_WIDTH-1:0] shift_q;
    logic                        half_done;
    logic                        full_done;
    logic                        data_sample;
    logic                        stop_sample;

    assign rx_line     = sync_q[1];
    assign half_done   = (cnt_q == HALF_LAST);
    assign full_done   = (cnt_q == BAUD_LAST);
    assign data_sample = (state_q == RX_DATA) && full_done;
    assign stop_sample = (state_q == RX_STOP) && full_done;

    // Two-flop synchronizer, resets to the idle level
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], uart_rx_i};
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q     <= RX_IDLE;
            cnt_q       <= '0;
            bit_idx_q   <= '0;
            rx_valid_o  <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            rx_valid_o  <= 1'b0;   // Strobes default low
            frame_err_o <= 1'b0;
            cnt_q       <= cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (!rx_line) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_done) begin
                        cnt_q     <= '0;
                        bit_idx_q <= '0;
                        if (rx_line) begin
                            state_q <= RX_IDLE;   // Glitch, no frame
                        end else begin
                            state_q <= RX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (full_done) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == IDX_LAST) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (full_done) begin
                        cnt_q       <= '0;
                        state_q     <= RX_IDLE;
                        rx_valid_o  <= rx_line;
                        frame_err_o <= !rx_line;   // Stop bit sampled low
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first and ends up at bit 0
    always_ff @(posedge clk_i) begin
        if (data_sample) begin
            shift_q <= {rx_line, shift_q[`UART_DATA_WIDTH-1:1]};
        end
        if (stop_sample && rx_line) begin
            rx_data_o <= shift_q;
        end
    end

endmodule

// ==== uart_top.sv ====
// UART subsystem top
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_top (
    input  logic                        clk_i,
    input  logic                        arstn_i,

    // Transmit stream
    input  logic                        tx_valid_i,
    input  logic [`UART_DATA_WIDTH-1:0] tx_data_i,
    output logic                        tx_ready_o,

    // Receive strobes
    output logic                        rx_valid_o,
    output logic [`UART_DATA_WIDTH-1:0] rx_data_o,
    output logic                        frame_err_o,

    // Serial pins
    output logic                        uart_tx_o,
    input  logic                        uart_rx_i
);

    uart_tx u_uart_tx (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .tx_valid_i (tx_valid_i),
        .tx_data_i  (tx_data_i),
        .tx_ready_o (tx_ready_o),
        .uart_tx_o  (uart_tx_o)
    );

    // Serial loop is closed outside this level
    uart_rx u_uart_rx (
        .clk_i       (clk_i),
        .arstn_i     (arstn_i),
        .uart_rx_i   (uart_rx_i),
        .rx_valid_o  (rx_valid_o),
        .rx_data_o   (rx_data_o),
        .frame_err_o (frame_err_o)
    );

endmodule

// ==== uart_tx.sv ====
// UART transmitter
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        arstn_i,
    input  logic                        tx_valid_i,
    input  logic [`UART_DATA_WIDTH-1:0] tx_data_i,
    output logic                        tx_ready_o,
    output logic                        uart_tx_o
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`UART_DATA_WIDTH);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(`UART_DATA_WIDTH - 1);

    tx_state_e                   state_q;
    tx_state_e                   state_d;
    logic [CNT_W-1:0]            baud_cnt_q;
    logic [IDX_W-1:0]            bit_idx_q;
    logic [IDX_W-1:0]            bit_idx_d;
    logic [`UART_DATA_WIDTH-1:0] tx_byte_q;
    logic                        accept;
    logic                        counting;
    logic                        baud_done;
    logic                        line_d;

    assign tx_ready_o = (state_q == TX_IDLE);
    assign accept     = tx_valid_i && tx_ready_o;
    assign counting   = (state_q == TX_START) || (state_q == TX_DATA) || (state_q == TX_STOP);
    assign baud_done  = counting && (baud_cnt_q == BAUD_LAST);

    always_comb begin
        state_d   = state_q;
        bit_idx_d = bit_idx_q;
        case (state_q)
            TX_IDLE: begin
                if (accept) begin
                    state_d = TX_START;
                end
            end
            TX_START: begin
                if (baud_done) begin
                    state_d = TX_DATA;
                end
            end
            TX_DATA: begin
                if (baud_done) begin
                    bit_idx_d = bit_idx_q + 1'b1;   // Wraps to zero after the MSB
                    if (bit_idx_q == IDX_LAST) begin
                        state_d = TX_STOP;
                    end
                end
            end
            TX_STOP: begin
                if (baud_done) begin
                    state_d = TX_GAP;
                end
            end
            TX_GAP:  state_d = TX_IDLE;
            default: state_d = TX_IDLE;
        endcase
    end

    // Line level for the state being entered, so the pin changes on the edge
    always_comb begin
        case (state_d)
            TX_START: line_d = 1'b0;
            TX_DATA:  line_d = tx_byte_q[bit_idx_d];
            default:  line_d = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state_q    <= TX_IDLE;
            bit_idx_q  <= '0;
            baud_cnt_q <= '0;
            uart_tx_o  <= 1'b1;   // Idle line
        end else begin
            state_q   <= state_d;
            bit_idx_q <= bit_idx_d;
            uart_tx_o <= line_d;
            if (!counting || baud_done) begin
                baud_cnt_q <= '0;
            end else begin
                baud_cnt_q <= baud_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tx_byte_q <= tx_data_i;
        end
    end

endmodule
